// ==== Makefile ====
# Verilator flow for the instruction cache tag side

TOP := icache_tag_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/icache_addr_pkg.sv ====
// Address field types for the instruction cache tag side
// Splits a fetch address into tag, line index and byte offset

`include "icache_config.svh"

package icache_addr_pkg;

    // =================================================================
    // Field widths
    // =================================================================
    localparam int ADDR_W      = `ICACHE_ADDR_W;
    localparam int OFFSET_W    = $clog2(`ICACHE_LINE_BYTES);  // Byte in line
    localparam int LINE_ADDR_W = $clog2(`ICACHE_LINES);       // Line index
    localparam int TAG_W       = ADDR_W - LINE_ADDR_W - OFFSET_W;

    // =================================================================
    // Types
    // =================================================================
    typedef logic [ADDR_W-1:0]      addr_t;       // Full fetch address
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;  // Index into a tag bank
    typedef logic [TAG_W-1:0]       tag_t;        // Bits above the index

    // Valid bit sits above the tag
    typedef logic [TAG_W:0]         tag_entry_t;

endpackage

// ==== design/icache_config.svh ====
// Instruction cache tag side configuration
// Geometry and fill timing shared by the packages and the RTL

`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// =====================================================================
// Address geometry
// =====================================================================
`define ICACHE_ADDR_W       32  // Fetch address width
`define ICACHE_LINE_BYTES   16  // Bytes per cache line
`define ICACHE_LINES        64  // Lines per way, power of two

// =====================================================================
// Organization and timing
// =====================================================================
`define ICACHE_WAYS         2   // Associativity
`define ICACHE_FILL_LATENCY 6   // Cycles spent in FILL_WAIT per miss

`endif

// ==== design/icache_ctrl_pkg.sv ====
// Controller types for the instruction cache tag side
// FSM state, one-hot way masks and the fill latency counter

`include "icache_config.svh"

package icache_ctrl_pkg;

    // One bit per way, one-hot for hits and victims
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

    // Counts 0 .. fill latency - 1 in FILL_WAIT
    localparam int FILL_CNT_W = $clog2(`ICACHE_FILL_LATENCY + 1);
    typedef logic [FILL_CNT_W-1:0] fill_cnt_t;

    // =================================================================
    // Miss and flush FSM
    // =================================================================
    typedef enum logic [1:0] {
        IDLE,        // Lookups flow through the pipeline
        FILL_WAIT,   // Stand-in for memory latency
        FILL_WRITE,  // Victim way gets the new tag
        FLUSH        // Sweep that clears every valid bit
    } ctrl_state_t;

endpackage

// ==== design/icache_tag_ctrl.sv ====
// Instruction cache tag controller
// Runs the two-stage lookup, reports hit or miss, waits out the fill
// latency on a miss, writes the round-robin victim, and sweeps all
// lines on a flush or after reset

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_tag_ctrl
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  addr_t     req_addr,
    input  logic      flush,
    output logic      busy,
    output logic      resp_valid,
    output logic      resp_hit,
    output way_mask_t resp_way,
    icache_tag_if.ctrl tags
);

    localparam line_addr_t LAST_LINE = line_addr_t'(`ICACHE_LINES - 1);
    localparam fill_cnt_t  LAST_WAIT = fill_cnt_t'(`ICACHE_FILL_LATENCY - 1);

    ctrl_state_t state;
    line_addr_t  req_line;       // Index field of req_addr
    tag_t        req_tag;        // Tag field of req_addr
    logic        accept_req;
    logic        accept_flush;
    logic        miss;           // Stage-2 lookup found no way

    // Stage 2 of the lookup
    logic        stage2_valid;
    line_addr_t  stage2_line_q;
    tag_t        stage2_tag_q;

    // Miss and flush bookkeeping
    line_addr_t  fill_line;      // Latched miss address
    tag_t        fill_tag;
    fill_cnt_t   fill_cnt;
    line_addr_t  sweep_line;     // Flush sweep position
    way_mask_t   victim;         // Round-robin pointer, one-hot

    // =================================================================
    // Request decode and acceptance
    // =================================================================
    assign req_line = req_addr[OFFSET_W +: LINE_ADDR_W];
    assign req_tag  = req_addr[ADDR_W-1 -: TAG_W];

    assign miss = stage2_valid && !tags.tag_hit;
    assign busy = (state != IDLE) || miss;  // Miss stalls in its own cycle

    assign accept_flush = flush && !busy;
    assign accept_req   = req && !busy && !flush;  // Flush wins a tie

    // Response straight out of stage 2
    assign resp_valid = stage2_valid;
    assign resp_hit   = stage2_valid && tags.tag_hit;
    assign resp_way   = tags.tag_hit_way;         // Zero on a miss

    // =================================================================
    // Lookup pipeline
    // =================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            stage2_valid <= 1'b0;
        end else begin
            stage2_valid <= accept_req;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_req) begin
            stage2_line_q <= req_line;
            stage2_tag_q  <= req_tag;
        end
        if (state == IDLE && miss) begin  // Hold the missed address
            fill_line <= stage2_line_q;
            fill_tag  <= stage2_tag_q;
        end
    end

    // =================================================================
    // Miss fill and flush FSM
    // =================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= FLUSH;  // Reset sweep clears every bank
            sweep_line <= '0;
            fill_cnt   <= '0;
            victim     <= way_mask_t'(1);
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        state    <= FILL_WAIT;
                        fill_cnt <= '0;
                    end else if (accept_flush) begin
                        state      <= FLUSH;
                        sweep_line <= '0;
                    end
                end
                FILL_WAIT: begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == LAST_WAIT) begin
                        state <= FILL_WRITE;
                    end
                end
                FILL_WRITE: begin
                    state  <= IDLE;
                    // Rotate left by one way
                    victim <= (victim << 1) | (victim >> (`ICACHE_WAYS - 1));
                end
                FLUSH: begin
                    sweep_line <= sweep_line + 1'b1;
                    if (sweep_line == LAST_LINE) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // =================================================================
    // Bank interface drive
    // =================================================================
    assign tags.stage1_line_addr = req_line;
    assign tags.stage1_adv       = accept_req;

    always_comb begin
        case (state)
            FILL_WRITE: begin
                tags.update           = 1'b1;
                tags.update_valid     = 1'b1;
                tags.update_way       = victim;
                tags.stage2_line_addr = fill_line;
                tags.stage2_tag       = fill_tag;
            end
            FLUSH: begin
                tags.update           = 1'b1;
                tags.update_valid     = 1'b0;  // Invalidate
                tags.update_way       = '1;    // All ways at once
                tags.stage2_line_addr = sweep_line;
                tags.stage2_tag       = '0;
            end
            default: begin
                tags.update           = 1'b0;
                tags.update_valid     = 1'b0;
                tags.update_way       = '0;
                tags.stage2_line_addr = stage2_line_q;
                tags.stage2_tag       = stage2_tag_q;  // Compare tag
            end
        endcase
    end

endmodule

// ==== design/icache_tag_if.sv ====
// Tag bank interface of the instruction cache
// Controller drives lookup and update, banks return per-way hits

`timescale 1ns/1ps

interface icache_tag_if
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;
();

    // Lookup side
    line_addr_t stage1_line_addr;  // Index of the incoming request
    logic       stage1_adv;        // Request accepted this cycle
    line_addr_t stage2_line_addr;  // Write index for port b
    tag_t       stage2_tag;        // Compare tag, also the write tag

    // Update side
    logic       update;            // Port b write enable
    logic       update_valid;      // Valid bit written with the tag
    way_mask_t  update_way;        // Ways written by this update

    // Compare result
    logic       tag_hit;
    way_mask_t  tag_hit_way;       // One-hot on a hit

    modport ctrl (
        output stage1_line_addr, stage1_adv,
        output stage2_line_addr, stage2_tag,
        output update, update_valid, update_way,
        input  tag_hit, tag_hit_way
    );

    modport banks (
        input  stage1_line_addr, stage1_adv,
        input  stage2_line_addr, stage2_tag,
        input  update, update_valid, update_way,
        output tag_hit, tag_hit_way
    );

endinterface

// ==== design/icache_tag_top.sv ====
// Instruction cache tag side top level
// Joins the controller and the tag bank group through the tag interface

`timescale 1ns/1ps

module icache_tag_top
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,         // Lookup strobe
    input  addr_t     req_addr,
    input  logic      flush,       // Invalidate all lines
    output logic      busy,        // Back-pressure level
    output logic      resp_valid,
    output logic      resp_hit,
    output way_mask_t resp_way
);

    // =================================================================
    // Controller to bank link
    // =================================================================
    icache_tag_if tags ();

    icache_tag_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_addr   (req_addr),
        .flush      (flush),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .resp_way   (resp_way),
        .tags       (tags.ctrl)
    );

    itag_banks u_banks (
        .clk  (clk),
        .rst  (rst),
        .tags (tags.banks)
    );

endmodule

// ==== design/itag_banks.sv ====
// Tag bank group of the instruction cache
// One bank per way, read on port a, tag update on port b,
// and the stage-2 compare that yields the hit vector

`timescale 1ns/1ps

`include "icache_config.svh"

module itag_banks
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    icache_tag_if.banks tags
);

    // =================================================================
    // Compare qualifier
    // =================================================================
    logic       hit_allowed;                  // Stage 2 holds a real lookup
    tag_entry_t way_entry [`ICACHE_WAYS];     // Read data per way
    way_mask_t  hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_allowed <= 1'b0;
        end else begin
            hit_allowed <= tags.stage1_adv;  // Read data valid next cycle
        end
    end

    // =================================================================
    // Banks and per-way compare
    // =================================================================
    for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : g_way
        tag_bank u_bank (
            .clk        (clk),
            // Lookup read
            .en_a       (tags.stage1_adv),
            .wen_a      (1'b0),
            .addr_a     (tags.stage1_line_addr),
            .data_in_a  ('0),
            .data_out_a (way_entry[i]),
            // Fill and flush write
            .en_b       (tags.update),
            .wen_b      (tags.update_way[i]),
            .addr_b     (tags.stage2_line_addr),
            .data_in_b  ({tags.update_valid, tags.stage2_tag}),
            .data_out_b ()
        );

        // Valid entry whose tag matches the stage-2 tag
        assign hit_way[i] = hit_allowed
                          && (way_entry[i] == {1'b1, tags.stage2_tag});
    end

    assign tags.tag_hit_way = hit_way;
    assign tags.tag_hit     = |hit_way;  // At most one way matches

endmodule

// ==== design/tag_bank.sv ====
// Tag bank for one way
// Dual-port RAM of valid plus tag, registered reads on both ports

`timescale 1ns/1ps

`include "icache_config.svh"

module tag_bank
    import icache_addr_pkg::*;
(
    input  logic       clk,

    // Port a
    input  logic       en_a,
    input  logic       wen_a,
    input  line_addr_t addr_a,
    input  tag_entry_t data_in_a,
    output tag_entry_t data_out_a,

    // Port b
    input  logic       en_b,
    input  logic       wen_b,
    input  line_addr_t addr_b,
    input  tag_entry_t data_in_b,
    output tag_entry_t data_out_b
);

    tag_entry_t mem [`ICACHE_LINES];  // Block RAM, contents not reset

    // Read-first on both ports
    always_ff @(posedge clk) begin
        if (en_a) begin
            if (wen_a) begin
                mem[addr_a] <= data_in_a;
            end
            data_out_a <= mem[addr_a];  // Old contents on a write
        end
        if (en_b) begin
            if (wen_b) begin
                mem[addr_b] <= data_in_b;
            end
            data_out_b <= mem[addr_b];
        end
    end

endmodule

// ==== flist.f ====
+incdir+design
design/icache_addr_pkg.sv
design/icache_ctrl_pkg.sv
design/icache_tag_if.sv
design/tag_bank.sv
design/itag_banks.sv
design/icache_tag_ctrl.sv
design/icache_tag_top.sv
sim/icache_tag_props.sv
sim/icache_tag_tb.sv

// ==== sim/icache_tag_props.sv ====
// Port protocol checks for the instruction cache tag side
// Bound to the top level, counts every assertion failure

`timescale 1ns/1ps

module icache_tag_props
    import icache_ctrl_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      req,
    input logic      flush,
    input logic      busy,
    input logic      resp_valid,
    input logic      resp_hit,
    input way_mask_t resp_way
);

    int   error_count = 0;           // Read by the testbench
    logic accepted;

    assign accepted = req && !busy && !flush;  // Flush wins a tie

    // Exactly one answer, one cycle after each accepted request
    p_resp_after_accept: assert property (@(posedge clk) disable iff (rst)
        resp_valid == $past(accepted))
        else begin error_count++; $error("resp_valid does not follow acceptance"); end

    p_hit_needs_valid: assert property (@(posedge clk) disable iff (rst)
        resp_hit |-> resp_valid)
        else begin error_count++; $error("resp_hit without resp_valid"); end

    p_way_onehot: assert property (@(posedge clk) disable iff (rst)
        resp_hit |-> $onehot(resp_way))
        else begin error_count++; $error("resp_way not one-hot on a hit"); end

    p_way_zero: assert property (@(posedge clk) disable iff (rst)
        !resp_hit |-> (resp_way == '0))
        else begin error_count++; $error("resp_way set without a hit"); end

    // Stalls for a miss and for a flush
    p_miss_busy: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && !resp_hit) |-> busy)
        else begin error_count++; $error("busy low in a miss cycle"); end

    p_flush_busy: assert property (@(posedge clk) disable iff (rst)
        $past(flush && !busy) |-> busy)
        else begin error_count++; $error("busy low after an accepted flush"); end

endmodule

bind icache_tag_top icache_tag_props u_props (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .flush      (flush),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_way   (resp_way)
);

// ==== sim/icache_tag_tb.sv ====
// Testbench for the instruction cache tag side
// Directed and xorshift lookups against a reference tag model,
// compared by concurrent assertions

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_tag_tb
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;
();

    localparam int N_REQ       = 300;  // Random stimulus cycles
    localparam int SEED        = 54293;
    localparam int CYCLE_LIMIT = 20 * N_REQ + 4 * `ICACHE_LINES;

    logic      clk;
    logic      rst;
    logic      req;
    addr_t     req_addr;
    logic      flush;
    logic      busy;
    logic      resp_valid;
    logic      resp_hit;
    way_mask_t resp_way;

    // =================================================================
    // Reference model state
    // =================================================================
    logic        model_valid [`ICACHE_LINES][`ICACHE_WAYS];
    tag_t        model_tag   [`ICACHE_LINES][`ICACHE_WAYS];
    int          victim_ptr;    // Round-robin fill way
    int          busy_left;     // Stall cycles still to come
    logic        exp_valid;
    logic        exp_hit;
    way_mask_t   exp_way;
    line_addr_t  exp_line;      // Address of the lookup in flight
    tag_t        exp_tag;
    logic        exp_busy;
    logic [31:0] rng;
    int          cycle_count = 0;

    icache_tag_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_addr   (req_addr),
        .flush      (flush),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .resp_way   (resp_way)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // =================================================================
    // Helpers
    // =================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic addr_t make_addr(input tag_t t, input line_addr_t l,
                                        input logic [OFFSET_W-1:0] off);
        return {t, l, off};
    endfunction

    // Few tags on few lines, so evictions are frequent
    function automatic tag_t pool_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return tag_t'(32'h0000_0abc);
            2'd1:    return tag_t'(32'h0001_2345);
            default: return tag_t'(32'h003f_ff00);
        endcase
    endfunction

    function automatic line_addr_t pool_line(input logic [1:0] sel);
        case (sel)
            2'd0:    return line_addr_t'(5);
            2'd1:    return line_addr_t'(6);
            2'd2:    return line_addr_t'(37);
            default: return line_addr_t'(63);
        endcase
    endfunction

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want);
        fail_run();
    endtask

    task automatic step();
        @(posedge clk);
        #2;  // Drive point
    endtask

    task automatic wait_idle();
        while (busy) step();
    endtask

    // Ends in the response cycle
    task automatic lookup(input addr_t addr);
        wait_idle();
        req      = 1'b1;
        req_addr = addr;
        step();
        req = 1'b0;
    endtask

    task automatic lookup_pair(input addr_t first, input addr_t second);
        wait_idle();
        req      = 1'b1;
        req_addr = first;
        step();
        req_addr = second;  // Second lookup while first is in stage 2
        step();
        req = 1'b0;
    endtask

    // Every one of these requests has to be dropped
    task automatic request_while_busy(input addr_t addr);
        req      = 1'b1;
        req_addr = addr;
        while (busy) step();
        req = 1'b0;
    endtask

    task automatic flush_all(input addr_t addr);
        wait_idle();
        flush    = 1'b1;
        req      = 1'b1;  // Loses to the flush
        req_addr = addr;
        step();
        flush = 1'b0;
        req   = 1'b0;
    endtask

    // =================================================================
    // Reference model
    // =================================================================
    assign exp_busy = (busy_left != 0) || (exp_valid && !exp_hit);

    always @(posedge clk) begin : model_update
        line_addr_t l;
        tag_t       t;
        way_mask_t  hit_way;
        logic       req_acc;
        logic       flush_acc;
        req_acc   = req && !exp_busy && !flush;
        flush_acc = flush && !exp_busy;
        if (rst) begin
            for (int i = 0; i < `ICACHE_LINES; i++)
                for (int w = 0; w < `ICACHE_WAYS; w++) model_valid[i][w] = 1'b0;
            victim_ptr = 0;
            busy_left <= `ICACHE_LINES;  // Reset sweep
            exp_valid <= 1'b0;
            exp_hit   <= 1'b0;
            exp_way   <= '0;
        end else begin
            if (exp_valid && !exp_hit) begin  // Miss fills the victim way
                model_valid[exp_line][victim_ptr] = 1'b1;
                model_tag[exp_line][victim_ptr]   = exp_tag;
                victim_ptr = (victim_ptr + 1) % `ICACHE_WAYS;
                busy_left <= `ICACHE_FILL_LATENCY + 1;
            end else if (flush_acc) begin
                for (int i = 0; i < `ICACHE_LINES; i++)
                    for (int w = 0; w < `ICACHE_WAYS; w++) model_valid[i][w] = 1'b0;
                busy_left <= `ICACHE_LINES;
            end else if (busy_left != 0) begin
                busy_left <= busy_left - 1;
            end
            if (req_acc) begin
                {t, l}  = req_addr[ADDR_W-1:OFFSET_W];  // Tag sits above the line
                hit_way = '0;
                for (int w = 0; w < `ICACHE_WAYS; w++)
                    if (model_valid[l][w] && model_tag[l][w] == t) hit_way[w] = 1'b1;
                exp_hit  <= |hit_way;
                exp_way  <= hit_way;  // Zero on a miss
                exp_line <= l;
                exp_tag  <= t;
            end
            exp_valid <= req_acc;
        end
    end

    // =================================================================
    // Checks against the model
    // =================================================================
    a_busy: assert property (@(posedge clk) disable iff (rst) busy == exp_busy)
        else report_mismatch("busy", 32'($sampled(busy)), 32'($sampled(exp_busy)));

    a_resp_valid: assert property (@(posedge clk) disable iff (rst)
        resp_valid == exp_valid)
        else report_mismatch("resp_valid", 32'($sampled(resp_valid)),
                             32'($sampled(exp_valid)));

    a_resp_hit: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> (resp_hit == exp_hit))
        else report_mismatch("resp_hit", 32'($sampled(resp_hit)), 32'($sampled(exp_hit)));

    a_resp_way: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> (resp_way == exp_way))
        else report_mismatch("resp_way", 32'($sampled(resp_way)), 32'($sampled(exp_way)));

    always @(negedge clk) begin
        if (u_dut.u_props.error_count != 0) begin
            $display("A protocol assertion on the DUT ports failed");
            fail_run();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            fail_run();
        end
    end

    // =================================================================
    // Stimulus
    // =================================================================
    initial begin
        rst      = 1'b1;
        req      = 1'b0;
        req_addr = '0;
        flush    = 1'b0;
        rng      = SEED;
        repeat (10) step();
        rst = 1'b0;
        wait_idle();  // Reset sweep

        lookup(make_addr(pool_tag(2'd0), pool_line(2'd3), '0));  // Cold miss
        lookup(make_addr(pool_tag(2'd0), pool_line(2'd0), '0));
        lookup(make_addr(pool_tag(2'd0), pool_line(2'd0), '0));  // Repeat hits
        lookup(make_addr(pool_tag(2'd1), pool_line(2'd0), '0));
        request_while_busy(make_addr(pool_tag(2'd2), pool_line(2'd1), '0));
        lookup_pair(make_addr(pool_tag(2'd0), pool_line(2'd0), '0),
                    make_addr(pool_tag(2'd1), pool_line(2'd0), '0));
        lookup(make_addr(pool_tag(2'd2), pool_line(2'd0), '0));  // Third tag evicts
        lookup(make_addr(pool_tag(2'd1), pool_line(2'd0), '0));
        lookup(make_addr(pool_tag(2'd0), pool_line(2'd0), '0));

        flush_all(make_addr(pool_tag(2'd1), pool_line(2'd0), '0));
        request_while_busy(make_addr(pool_tag(2'd1), pool_line(2'd0), '0));
        lookup(make_addr(pool_tag(2'd1), pool_line(2'd0), '0));  // Gone after flush
        lookup(make_addr(pool_tag(2'd2), pool_line(2'd0), '0));

        for (int n = 0; n < N_REQ; n++) begin
            rng      = xorshift32(rng);
            flush    = (rng[31:25] == 7'd0);  // Rare
            req      = rng[0] | rng[1];
            req_addr = make_addr(pool_tag(rng[3:2]), pool_line(rng[5:4]),
                                 rng[6 +: OFFSET_W]);
            step();
        end
        req   = 1'b0;
        flush = 1'b0;
        wait_idle();
        step();

        if (u_dut.u_props.error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule
